// File: Makefile
TOP = fpAdderTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^Done: no errors$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: addPath/fpAlign.sv
// Align stage that orders operands, shifts the smaller mantissa and adds or subtracts
`timescale 1ns/1ps

module fpAlign
(
    input  logic   clock,
    input  logic   reset,
    fpBus.consumer in,
    fpBus.producer out
);
    import fpPkg::*;

    logic                  aBigger;
    logic [30:0]           bigWord;
    logic [30:0]           smallWord;
    logic [expWidth-1:0]   expBig;
    logic [expWidth-1:0]   expSmall;
    logic [expWidth-1:0]   expDiff;
    logic [5:0]            shiftAmount;
    logic [alignWidth-1:0] manBig;
    logic [alignWidth-1:0] manSmall;
    logic [alignWidth-1:0] shiftedSmall;
    logic [alignWidth-1:0] lostBits;
    logic [alignWidth-1:0] alignedSmall;
    logic [alignWidth:0]   sum;
    logic                  sumSign;

    // Compare magnitude on exponent and fraction together
    assign aBigger   = in.a[30:0] >= in.b[30:0];
    assign bigWord   = aBigger ? in.a[30:0] : in.b[30:0];
    assign smallWord = aBigger ? in.b[30:0] : in.a[30:0];
    assign sumSign   = aBigger ? in.signA : in.signB;

    assign expBig   = bigWord[expWidth+manWidth-1:manWidth];
    assign expSmall = smallWord[expWidth+manWidth-1:manWidth];
    assign expDiff  = expBig - expSmall;

    // Hidden bit is set only for a nonzero exponent
    assign manBig   = {expBig != '0, bigWord[manWidth-1:0], 8'b0};
    assign manSmall = {expSmall != '0, smallWord[manWidth-1:0], 8'b0};

    // Beyond 32 places everything lands in sticky
    assign shiftAmount = (expDiff > 8'd32) ? 6'd32 : expDiff[5:0];
    assign {shiftedSmall, lostBits} = {manSmall, {alignWidth{1'b0}}} >> shiftAmount;
    assign alignedSmall = {shiftedSmall[alignWidth-1:1], shiftedSmall[0] | (|lostBits)};

    always_comb
    begin
        if (in.signA == in.signB)
            sum = {1'b0, manBig} + {1'b0, alignedSmall};
        else
            sum = {1'b0, manBig - alignedSmall};
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            out.valid <= 1'b0;
        else
            out.valid <= in.valid;
    end

    always_ff @(posedge clock)
    begin
        out.opcode        <= in.opcode;
        out.a             <= in.a;
        out.b             <= in.b;
        out.signA         <= in.signA;
        out.signB         <= in.signB;
        out.classA        <= in.classA;
        out.classB        <= in.classB;
        out.alignedSign   <= sumSign;
        out.exponentOut   <= expBig;
        // Carry sits above the top bit, normalize drops one bit for it
        out.alignedResult <= sum[alignWidth-1:0];
        out.carryOut      <= sum[alignWidth];
    end

endmodule

// File: addPath/fpUnpack.sv
// Unpack stage that registers an accepted operation and classifies both operands
`timescale 1ns/1ps

module fpUnpack
(
    input  logic        clock,
    input  logic        reset,
    input  logic        inValid,
    input  fpPkg::fpOp  opcode,
    input  logic [31:0] a,
    input  logic [31:0] b,
    fpBus.producer      out
);
    import fpPkg::*;

    logic        effSignB;
    logic [31:0] effB;

    function automatic fpClass classify(input logic [31:0] x);
        fpClass c;
        logic   expMax;
        logic   expZero;
        logic   fracZero;
        expMax   = &x[expWidth+manWidth-1:manWidth];
        expZero  = ~|x[expWidth+manWidth-1:manWidth];
        fracZero = ~|x[manWidth-1:0];
        c.isNaN  = expMax && !fracZero;
        c.isInf  = expMax && fracZero;
        // Exponent 0 with a nonzero fraction is kept as a number
        c.isZero = expZero && fracZero;
        return c;
    endfunction

    // Subtract is an add with B negated
    assign effSignB = b[31] ^ (opcode == opSub);
    assign effB     = {effSignB, b[30:0]};

    always_ff @(posedge clock)
    begin
        if (reset)
            out.valid <= 1'b0;
        else
            out.valid <= inValid;
    end

    always_ff @(posedge clock)
    begin
        out.opcode <= opcode;
        out.a      <= a;
        out.b      <= effB;
        out.signA  <= a[31];
        out.signB  <= effSignB;
        out.classA <= classify(a);
        out.classB <= classify(b);
    end

endmodule

// File: addPath/normalize.sv
// Normalize stage that renormalizes, rounds to nearest even and resolves special operands
`timescale 1ns/1ps

module normalize
(
    input  logic   clock,
    input  logic   reset,
    fpBus.consumer in,
    fpBus.producer out
);
    import fpPkg::*;

    logic [alignWidth-1:0] work;
    logic [alignWidth-1:0] rounded;
    logic [5:0]            shiftAmount;
    logic                  guard;
    logic                  round;
    logic                  sticky;
    logic                  roundUp;
    logic                  roundCarry;
    logic [9:0]            expWide;
    logic [manWidth-1:0]   manOut;
    logic [31:0]           normalWord;
    logic [31:0]           packedWord;

    function automatic logic [5:0] leadZeros(input logic [alignWidth-1:0] x);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i < alignWidth; i++)
            if (x[i])
                n = 6'(alignWidth - 1 - i);
        return n;
    endfunction

    always_comb
    begin
        if (in.carryOut)
        begin
            // Shift right once and fold the dropped bit into sticky
            shiftAmount = 6'd0;
            work = {1'b1, in.alignedResult[31:2], |in.alignedResult[1:0]};
        end
        else
        begin
            shiftAmount = leadZeros(in.alignedResult);
            work = in.alignedResult << shiftAmount;
        end

        guard   = work[7];
        round   = work[6];
        sticky  = |work[5:0];
        roundUp = guard && (round || sticky || work[8]);
        {roundCarry, rounded} = {1'b0, work} + {24'b0, roundUp, 8'b0};

        manOut  = roundCarry ? rounded[31:9] : rounded[30:8];
        expWide = {2'b0, in.exponentOut} + 10'(in.carryOut) + 10'(roundCarry)
                - {4'b0, shiftAmount};

        if (!in.carryOut && in.alignedResult == '0)
            normalWord = 32'h0;
        // Negative exponent clamps at 0
        else if (expWide[9])
            normalWord = {in.alignedSign, 8'h00, manOut};
        else if (expWide[8:0] >= 9'd255)
            normalWord = {in.alignedSign, 8'hFF, 23'h0};
        else
            normalWord = {in.alignedSign, expWide[7:0], manOut};
    end

    // NaN first, then infinity, then zero
    always_comb
    begin
        if (in.classA.isNaN)
            packedWord = in.a;
        else if (in.classB.isNaN)
            packedWord = in.b;
        else if (in.classA.isInf)
        begin
            if (in.classB.isInf && (in.signA != in.signB))
                packedWord = {1'b0, 8'hFF, 23'h7FFFFF};
            else
                packedWord = in.a;
        end
        else if (in.classB.isInf)
            packedWord = in.b;
        else if (in.classA.isZero && !in.classB.isZero)
            packedWord = in.b;
        else if (in.classA.isZero || in.classB.isZero)
            packedWord = in.a;
        else
            packedWord = normalWord;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            out.valid <= 1'b0;
        else
            out.valid <= in.valid;
    end

    always_ff @(posedge clock)
    begin
        out.result <= packedWord;
    end

endmodule

// File: common/fpBus.sv
// Stage bus carrying one floating-point operation between pipeline registers
`timescale 1ns/1ps

interface fpBus;
    import fpPkg::*;

    logic                  valid;
    fpOp                   opcode;
    logic [31:0]           a;
    logic [31:0]           b;
    logic                  signA;
    logic                  signB;
    fpClass                classA;
    fpClass                classB;

    // Aligned sum from the add stage
    logic                  alignedSign;
    logic [expWidth-1:0]   exponentOut;
    logic [alignWidth-1:0] alignedResult;
    logic                  carryOut;

    // Packed result after normalize
    logic [31:0]           result;

    modport producer
    (
        output valid, opcode, a, b, signA, signB, classA, classB,
        output alignedSign, exponentOut, alignedResult, carryOut, result
    );

    modport consumer
    (
        input valid, opcode, a, b, signA, signB, classA, classB,
        input alignedSign, exponentOut, alignedResult, carryOut, result
    );

endinterface

// File: common/fpPkg.sv
// Floating-point adder package with field widths, opcodes, operand classes and credit counts
package fpPkg;

    // Single-precision field layout
    localparam int expWidth = 8;
    localparam int manWidth = 23;

    // Working mantissa: hidden bit and fraction in 31..8, guard/round/sticky in 7..0
    localparam int alignWidth = 32;

    // Result queue entries, also the upstream credits held after reset
    localparam int queueDepth = 4;

    // Downstream credits held by the adder after reset
    localparam int outCreditInit = 2;

    // Unpack, align and normalize registers
    localparam int pipeDepth = 3;

    typedef enum logic
    {
        opAdd = 1'b0,
        opSub = 1'b1
    } fpOp;

    typedef struct packed
    {
        logic isNaN;
        logic isInf;
        logic isZero;
    } fpClass;

endpackage

// File: design/fpAdder.sv
// Pipelined single-precision adder and subtracter with credit-based result flow
`timescale 1ns/1ps

module fpAdder
(
    input  logic        clock,
    input  logic        reset,
    input  logic        inValid,
    input  fpPkg::fpOp  opcode,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        inCredit,
    output logic        outValid,
    output logic [31:0] result,
    input  logic        outCredit
);

    fpBus unpackBus();
    fpBus alignBus();
    fpBus normBus();

    fpUnpack i_unpack
    (
        .clock   (clock),
        .reset   (reset),
        .inValid (inValid),
        .opcode  (opcode),
        .a       (a),
        .b       (b),
        .out     (unpackBus.producer)
    );

    fpAlign i_align
    (
        .clock (clock),
        .reset (reset),
        .in    (unpackBus.consumer),
        .out   (alignBus.producer)
    );

    normalize i_normalize
    (
        .clock (clock),
        .reset (reset),
        .in    (alignBus.consumer),
        .out   (normBus.producer)
    );

    resultQueue i_queue
    (
        .clock     (clock),
        .reset     (reset),
        .in        (normBus.consumer),
        .outCredit (outCredit),
        .outValid  (outValid),
        .result    (result),
        .inCredit  (inCredit)
    );

endmodule

// File: design/resultQueue.sv
// Result queue that releases results on downstream credit and returns upstream credits
`timescale 1ns/1ps

module resultQueue
(
    input  logic        clock,
    input  logic        reset,
    fpBus.consumer      in,
    input  logic        outCredit,
    output logic        outValid,
    output logic [31:0] result,
    output logic        inCredit
);
    import fpPkg::*;

    logic [31:0]                   entries [queueDepth];
    logic [$clog2(queueDepth)-1:0] wrPtr;
    logic [$clog2(queueDepth)-1:0] rdPtr;
    logic [2:0]                    count;
    logic [2:0]                    credits;
    logic                          push;
    logic                          pop;

    // Upstream credits keep the queue from overfilling
    assign push = in.valid;
    assign pop  = (count != 3'd0) && (credits != 3'd0);

    assign outValid = pop;
    assign result   = entries[rdPtr];
    assign inCredit = pop;

    always_ff @(posedge clock)
    begin
        if (push)
            entries[wrPtr] <= in.result;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= 3'd0;
            credits <= 3'(outCreditInit);
        end
        else
        begin
            if (push)
                wrPtr <= wrPtr + 1'b1;
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            count <= count + 3'(push) - 3'(pop);
            case ({pop, outCredit})
                2'b10:   credits <= credits - 3'd1;
                2'b01:   credits <= credits + 3'd1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: list.f
common/fpPkg.sv
common/fpBus.sv
addPath/fpUnpack.sv
addPath/fpAlign.sv
addPath/normalize.sv
design/resultQueue.sv
design/fpAdder.sv
tb/fpAdderTb.sv

// File: tb/fpAdderTb.sv
// Testbench for the pipelined floating-point adder with credit-aware driver and monitor
`timescale 1ns/1ps

module fpAdderTb;
    import fpPkg::*;

    // Tests take a few hundred cycles
    localparam int cycleLimit   = 2000;
    localparam int returnAlways = 0;
    localparam int returnNever  = 1;
    localparam int returnRandom = 2;

    logic        clock;
    logic        reset;
    logic        inValid;
    fpOp         opcode;
    logic [31:0] a;
    logic [31:0] b;
    logic        inCredit;
    logic        outValid;
    logic [31:0] result;
    logic        outCredit = 1'b0;

    logic [31:0] expectQ [$];
    logic [31:0] expectedWord;
    integer      seed;
    int          returnDraw;
    int          errors;
    int          cycles;
    int          heldCredits;
    int          pendingReturn;
    int          issuedCount;
    int          resultCount;
    int          inCreditCount;
    int          returnPolicy;

    fpAdder i_dut
    (
        .clock     (clock),
        .reset     (reset),
        .inValid   (inValid),
        .opcode    (opcode),
        .a         (a),
        .b         (b),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .result    (result),
        .outCredit (outCredit)
    );

    initial
    begin
        clock = 1'b0;
        forever
            #50 clock = ~clock;
    end

    // Double to single with round half to even on the dropped bits
    function automatic logic [31:0] toSingle(input real r);
        logic [63:0] d;
        logic [24:0] m;
        int          e;
        d = $realtobits(r);
        if (d[62:52] == 11'd0)
            return {d[63], 31'b0};
        e = int'(d[62:52]) - 1023 + 127;
        m = {2'b01, d[51:29]};
        if (d[28] && ((|d[27:0]) || m[0]))
            m = m + 25'd1;
        if (m[24])
        begin
            m = m >> 1;
            e = e + 1;
        end
        if (e >= 255)
            return {d[63], 8'hFF, 23'h0};
        if (e <= 0)
            return {d[63], 31'b0};
        return {d[63], e[7:0], m[22:0]};
    endfunction

    function automatic real fromSingle(input logic [31:0] s);
        logic [10:0] e;
        if (s[30:23] == 8'd0)
            return 0.0;
        e = {3'b0, s[30:23]} + 11'd896;
        return $bitstoreal({s[31], e, s[22:0], 29'b0});
    endfunction

    function automatic logic [31:0] expectedSum(input logic [31:0] x, input logic [31:0] y,
                                                input fpOp op);
        if (op == opSub)
            return toSingle(fromSingle(x) - fromSingle(y));
        return toSingle(fromSingle(x) + fromSingle(y));
    endfunction

    task automatic driveCycle(input logic want, input logic [31:0] x, input logic [31:0] y,
                              input fpOp op, input logic [31:0] expected, output logic issued);
        @(posedge clock);
        issued = want && (heldCredits > 0);
        if (issued)
        begin
            inValid <= 1'b1;
            opcode  <= op;
            a       <= x;
            b       <= y;
            heldCredits--;
            issuedCount++;
            expectQ.push_back(expected);
        end
        else
            inValid <= 1'b0;
    endtask

    task automatic issueOp(input logic [31:0] x, input logic [31:0] y, input fpOp op,
                           input logic [31:0] expected);
        logic done;
        done = 1'b0;
        while (!done)
            driveCycle(1'b1, x, y, op, expected, done);
    endtask

    task automatic sumCase(input real x, input real y, input fpOp op);
        issueOp(toSingle(x), toSingle(y), op, expectedSum(toSingle(x), toSingle(y), op));
    endtask

    task automatic waitDrain();
        @(posedge clock);
        inValid <= 1'b0;
        while (expectQ.size() != 0)
            @(posedge clock);
        // Let the last credit go back
        repeat (2) @(posedge clock);
    endtask

    task automatic testExactSums();
        sumCase(1.5, 2.5, opAdd);
        sumCase(3.0, 2.5, opSub);
        sumCase(10.0, 0.5, opAdd);
        sumCase(-7.5, 8.0, opAdd);
        sumCase(100.0, 99.5, opSub);
        sumCase(0.5, 0.5, opAdd);
        sumCase(-2.5, 3.5, opSub);
        sumCase(6.0, 6.0, opSub);
        waitDrain();
    endtask

    task automatic testRounding();
        // Halfway cases go to the even mantissa
        issueOp(32'h3F800000, 32'h33800000, opAdd, 32'h3F800000);
        issueOp(32'h3F800001, 32'h33800000, opAdd, 32'h3F800002);
        issueOp(32'h3F800000, 32'h33800001, opAdd, 32'h3F800001);
        issueOp(32'h3FFFFFFF, 32'h33800000, opAdd, 32'h40000000);
        waitDrain();
    endtask

    task automatic testSpecials();
        issueOp(32'h7FC00001, 32'h3F800000, opAdd, 32'h7FC00001);
        issueOp(32'h3F800000, 32'h7FC00002, opAdd, 32'h7FC00002);
        issueOp(32'h7FC00001, 32'hFFC00003, opAdd, 32'h7FC00001);
        issueOp(32'h7F800000, 32'h40400000, opAdd, 32'h7F800000);
        issueOp(32'hC0400000, 32'hFF800000, opAdd, 32'hFF800000);
        issueOp(32'h7F800000, 32'h7F800000, opSub, 32'h7FFFFFFF);
        issueOp(32'h00000000, 32'h40600000, opAdd, 32'h40600000);
        issueOp(32'h40600000, 32'h00000000, opSub, 32'h40600000);
        issueOp(32'h7F7FFFFF, 32'h7F7FFFFF, opAdd, 32'h7F800000);
        waitDrain();
    endtask

    task automatic testCreditLimits();
        int          startResults;
        int          startCredits;
        int          startIssued;
        int          got;
        logic        done;
        logic [31:0] x;
        returnPolicy = returnNever;
        startResults = resultCount;
        startCredits = inCreditCount;
        startIssued  = issuedCount;
        for (int i = 0; i < 30; i++)
        begin
            x = toSingle(real'(i + 1));
            driveCycle(1'b1, x, 32'h3F000000, opAdd, expectedSum(x, 32'h3F000000, opAdd), done);
        end
        driveCycle(1'b0, 32'h0, 32'h0, opAdd, 32'h0, done);
        got = resultCount - startResults;
        assert (got == outCreditInit)
        else
        begin
            $display("CHECK FAILED at %0t: %0d results without credit return", $time, got);
            errors++;
        end
        assert (inCreditCount - startCredits == got)
        else
        begin
            $display("CHECK FAILED at %0t: inCredit pulses differ from results", $time);
            errors++;
        end
        assert (issuedCount - startIssued - got == queueDepth)
        else
        begin
            $display("CHECK FAILED at %0t: driver did not stall at queue depth", $time);
            errors++;
        end
        returnPolicy = returnAlways;
        waitDrain();
        assert (inCreditCount - startCredits == issuedCount - startIssued)
        else
        begin
            $display("CHECK FAILED at %0t: credits not all returned after drain", $time);
            errors++;
        end
    endtask

    task automatic testRandomBackPressure();
        int   startResults;
        int   startCredits;
        real  x;
        real  y;
        fpOp  op;
        returnPolicy = returnRandom;
        startResults = resultCount;
        startCredits = inCreditCount;
        for (int i = 0; i < 40; i++)
        begin
            x = real'($random(seed) % 200) / 2.0;
            y = real'($random(seed) % 200) / 2.0;
            if ($random(seed) & 1)
                op = opSub;
            else
                op = opAdd;
            sumCase(x, y, op);
        end
        waitDrain();
        assert ((resultCount - startResults == 40) && (inCreditCount - startCredits == 40))
        else
        begin
            $display("CHECK FAILED at %0t: %0d results and %0d inCredit pulses for 40 ops",
                     $time, resultCount - startResults, inCreditCount - startCredits);
            errors++;
        end
    endtask

    // Monitor samples between edges
    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (inCredit)
            begin
                heldCredits++;
                inCreditCount++;
            end
            if (outValid)
            begin
                resultCount++;
                pendingReturn++;
                if (expectQ.size() == 0)
                begin
                    $display("Result %h arrived with no operation waiting for it", result);
                    errors++;
                end
                else
                begin
                    expectedWord = expectQ.pop_front();
                    assert (result == expectedWord)
                    else
                    begin
                        $display("CHECK FAILED at %0t: result %h, expected %h",
                                 $time, result, expectedWord);
                        errors++;
                    end
                end
            end
        end
    end

    // Coin for random credit return
    always @(negedge clock)
        returnDraw = $random(seed);

    // Downstream hands back one credit per consumed result
    always @(posedge clock)
    begin
        if (reset)
            outCredit <= 1'b0;
        else if (pendingReturn > 0 && (returnPolicy == returnAlways ||
                 (returnPolicy == returnRandom && (returnDraw & 1))))
        begin
            outCredit <= 1'b1;
            pendingReturn--;
        end
        else
            outCredit <= 1'b0;
    end

    always @(posedge clock)
    begin
        cycles++;
        if (cycles >= cycleLimit)
        begin
            $display("Timeout after %0d cycles with %0d results still outstanding",
                     cycles, expectQ.size());
            $display("Errors: %0d, issued: %0d, results: %0d", errors, issuedCount, resultCount);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        seed          = 32'hb0fc_4d7d;
        errors        = 0;
        cycles        = 0;
        pendingReturn = 0;
        issuedCount   = 0;
        resultCount   = 0;
        inCreditCount = 0;
        heldCredits   = queueDepth;
        returnPolicy  = returnAlways;
        reset         = 1'b1;
        inValid       = 1'b0;
        opcode        = opAdd;
        a             = 32'h0;
        b             = 32'h0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        testExactSums();
        testRounding();
        testSpecials();
        testCreditLimits();
        testRandomBackPressure();
        $display("Errors: %0d, issued: %0d, results: %0d", errors, issuedCount, resultCount);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
